/* common/grad_defines.svh */
`ifndef GRAD_DEFINES_SVH
`define GRAD_DEFINES_SVH

// image geometry.
`define IMG_W 256
`define IMG_H 256

// memory address width, one word per pixel.
`define ADDR_W 16

// total pixels in the image.
`define PIX_N 65536

`endif

/* common/grad_pkg.sv */
`include "grad_defines.svh"

package grad_pkg;

    typedef logic [7:0] pixel_t;          // unsigned grayscale.

    typedef logic signed [9:0] coef_t;    // pixel difference, -255..255.

    // gradient memory word, gx in the upper half.
    typedef struct packed {
        coef_t gx;
        coef_t gy;
    } grad_t;

    // pixel with its raster coordinates.
    typedef struct packed {
        pixel_t                    pixel;
        logic [`ADDR_W/2-1:0]      x;
        logic [`ADDR_W/2-1:0]      y;
        logic                      flush;   // padding beat after the image.
    } pix_beat_t;

    // result word and its destination.
    typedef struct packed {
        grad_t                 grad;
        logic [`ADDR_W-1:0]    addr;
    } grad_beat_t;

endpackage

/* source/pixel_reader.sv */
`include "grad_defines.svh"

module pixel_reader (
    input  logic                clk,
    input  logic                reset,
    output logic                img_rd,
    output logic [`ADDR_W-1:0]  img_addr,
    input  grad_pkg::pixel_t    img_di,
    output grad_pkg::pix_beat_t pix_beat,
    output logic                pix_valid
);
    import grad_pkg::*;

    localparam int SLOT_W = `ADDR_W + 1;
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PIX_N + `IMG_W - 1);

    logic [SLOT_W-1:0]  slot;         // next slot, image reads then flush.
    logic               finished;
    logic               flush_slot;   // flush slot issued this cycle.
    logic               slot_v_d;
    logic               flush_d;
    logic [`ADDR_W-1:0] addr_d;       // lines up with img_di.
    pix_beat_t          beat_next;

    // one slot per cycle from reset release until the last flush slot.
    always_ff @(posedge clk) begin
        if (reset) begin
            slot       <= '0;
            finished   <= 1'b0;
            img_rd     <= 1'b0;
            flush_slot <= 1'b0;
        end else if (!finished) begin
            img_rd     <= !slot[`ADDR_W];     // below PIX_N.
            flush_slot <= slot[`ADDR_W];
            finished   <= (slot == LAST_SLOT);
            slot       <= slot + 1'b1;
        end else begin
            img_rd     <= 1'b0;
            flush_slot <= 1'b0;
        end
    end

    // flush slots wrap to the first row coordinates.
    always_ff @(posedge clk) begin
        img_addr <= slot[`ADDR_W-1:0];
        addr_d   <= img_addr;
        pix_beat <= beat_next;
    end

    // memory latency stage, then the beat register.
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_v_d  <= 1'b0;
            flush_d   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            slot_v_d  <= img_rd | flush_slot;
            flush_d   <= flush_slot;
            pix_valid <= slot_v_d;
        end
    end

    always_comb begin
        beat_next.pixel = flush_d ? '0 : img_di;
        beat_next.x     = addr_d[`ADDR_W/2-1:0];
        beat_next.y     = addr_d[`ADDR_W-1:`ADDR_W/2];
        beat_next.flush = flush_d;
    end

endmodule

/* gradient/line_delay.sv */
`include "grad_defines.svh"

module line_delay (
    input  logic             clk,
    input  logic             reset,
    input  logic             shift,
    input  grad_pkg::pixel_t din,
    output grad_pkg::pixel_t tap_row,
    output grad_pkg::pixel_t tap_row_next
);
    import grad_pkg::*;

    // taps[0] is the newest pixel, taps[IMG_W-1] the oldest.
    pixel_t taps [`IMG_W];

    // one row of history, advanced only on valid beats.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `IMG_W; i++) begin
                taps[i] <= '0;
            end
        end else if (shift) begin
            taps[0] <= din;
            for (int i = 1; i < `IMG_W; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // with beat n+IMG_W at din, the oldest entry is pixel n.
    assign tap_row      = taps[`IMG_W-1];
    assign tap_row_next = taps[`IMG_W-2];   // pixel n+1, right neighbour.

endmodule

/* gradient/gradient_calc.sv */
`include "grad_defines.svh"

module gradient_calc (
    input  logic                 clk,
    input  logic                 reset,
    input  grad_pkg::pix_beat_t  pix_beat,
    input  logic                 pix_valid,
    output grad_pkg::grad_beat_t grad_beat,
    output logic                 grad_valid
);
    import grad_pkg::*;

    pixel_t up;          // pixel one row above the incoming one.
    pixel_t up_right;    // its right neighbour.
    coef_t  gx;
    coef_t  gy;
    logic   last_col;
    logic   emit;

    // zero-extend both operands so the difference keeps its sign.
    function automatic coef_t pix_diff(input pixel_t a, input pixel_t b);
        return coef_t'({2'b00, a}) - coef_t'({2'b00, b});
    endfunction

    line_delay line_delay_i (
        .clk          (clk),
        .reset        (reset),
        .shift        (pix_valid),
        .din          (pix_beat.pixel),
        .tap_row      (up),
        .tap_row_next (up_right)
    );

    // output column equals the incoming column.
    assign last_col = (pix_beat.x == (`ADDR_W/2)'(`IMG_W - 1));

    assign gx = last_col ? '0 : pix_diff(up_right, up);
    assign gy = pix_beat.flush ? '0 : pix_diff(pix_beat.pixel, up);   // last row.

    // nothing to emit until the second row starts arriving.
    assign emit = pix_valid && (pix_beat.y != '0 || pix_beat.flush);

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_valid <= 1'b0;
        end else begin
            grad_valid <= emit;
        end
    end

    // flush beats wrap to row 0, so one row back lands on the last row.
    always_ff @(posedge clk) begin
        grad_beat.grad.gx <= gx;
        grad_beat.grad.gy <= gy;
        grad_beat.addr    <= {pix_beat.y, pix_beat.x} - `ADDR_W'(`IMG_W);
    end

endmodule

/* source/grad_writer.sv */
`include "grad_defines.svh"

module grad_writer (
    input  logic                 clk,
    input  logic                 reset,
    input  grad_pkg::grad_beat_t grad_beat,
    input  logic                 grad_valid,
    output logic                 grad_wr,
    output logic [`ADDR_W-1:0]   grad_addr,
    output grad_pkg::grad_t      grad_do,
    output logic                 done
);

    logic last_wr;

    // final word of the image going out this cycle.
    assign last_wr = grad_wr && (grad_addr == `ADDR_W'(`PIX_N - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            done    <= 1'b0;
        end else begin
            grad_wr <= grad_valid;
            done    <= done | last_wr;   // sticky until reset.
        end
    end

    // memory port payload.
    always_ff @(posedge clk) begin
        grad_addr <= grad_beat.addr;
        grad_do   <= grad_beat.grad;
    end

endmodule

/* source/image_gradient.sv */
`include "grad_defines.svh"

module image_gradient (
    input  logic               clk,
    input  logic               reset,
    output logic               img_rd,
    output logic [`ADDR_W-1:0] img_addr,
    input  grad_pkg::pixel_t   img_di,
    output logic               grad_wr,
    output logic [`ADDR_W-1:0] grad_addr,
    output grad_pkg::grad_t    grad_do,
    output logic               done
);
    import grad_pkg::*;

    pix_beat_t  pix_beat;
    logic       pix_valid;
    grad_beat_t grad_beat;
    logic       grad_valid;

    pixel_reader pixel_reader_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_beat  (pix_beat),
        .pix_valid (pix_valid)
    );

    gradient_calc gradient_calc_i (
        .clk        (clk),
        .reset      (reset),
        .pix_beat   (pix_beat),
        .pix_valid  (pix_valid),
        .grad_beat  (grad_beat),
        .grad_valid (grad_valid)
    );

    grad_writer grad_writer_i (
        .clk        (clk),
        .reset      (reset),
        .grad_beat  (grad_beat),
        .grad_valid (grad_valid),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

/* dv/image_gradient_properties.sv */
`include "grad_defines.svh"

module image_gradient_properties (
    input logic               clk,
    input logic               reset,
    input logic               img_rd,
    input logic               grad_wr,
    input logic [`ADDR_W-1:0] grad_addr,
    input logic               done
);

    // frame complete, no more writes.
    no_write_when_done: assert property (
        @(posedge clk) disable iff (reset) !(grad_wr && done)
    ) else $error("grad_wr high while done is set");

    done_is_sticky: assert property (
        @(posedge clk) $fell(done) |-> $past(reset)
    ) else $error("done fell without a reset");

    // writes stream out back to back in raster order.
    write_addr_steps: assert property (
        @(posedge clk) disable iff (reset)
        (grad_wr && $past(grad_wr)) |-> (grad_addr == $past(grad_addr) + `ADDR_W'(1))
    ) else $error("consecutive write addresses do not increase by one");

    idle_after_reset: assert property (
        @(posedge clk) reset |=> (!img_rd && !grad_wr)
    ) else $error("img_rd or grad_wr high in the cycle after reset");

endmodule

bind image_gradient image_gradient_properties image_gradient_properties_i (
    .clk       (clk),
    .reset     (reset),
    .img_rd    (img_rd),
    .grad_wr   (grad_wr),
    .grad_addr (grad_addr),
    .done      (done)
);

/* dv/image_gradient_tb.sv */
`include "grad_defines.svh"

module image_gradient_tb;
    import grad_pkg::*;

    localparam int RUN_LIMIT = `PIX_N + `IMG_W + 400;   // cycles allowed for one frame.
    localparam int LATENCY   = `IMG_W + 4;              // read to write of one index.

    logic               clk;
    logic               reset;
    logic               img_rd;
    logic [`ADDR_W-1:0] img_addr;
    pixel_t             img_di = '0;
    logic               grad_wr;
    logic [`ADDR_W-1:0] grad_addr;
    grad_t              grad_do;
    logic               done;

    pixel_t             image       [`PIX_N];
    grad_t              grad_mem    [`PIX_N];
    int                 write_count [`PIX_N];
    int                 read_cycle  [`PIX_N];
    int                 cycle = 0;
    logic [`ADDR_W-1:0] next_addr;      // expected address of the next write.
    logic [15:0]        lfsr;

    image_gradient image_gradient_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_grad(input string name, input logic [`ADDR_W-1:0] addr,
                              input grad_t want, input grad_t got);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s addr %0d expected gx %0d gy %0d actual gx %0d gy %0d",
                               name, addr, want.gx, want.gy, got.gx, got.gy));
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADDR_W-1:0] want,
                              input logic [`ADDR_W-1:0] got);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s expected %0d actual %0d", name, want, got));
        end
    endtask

    task automatic check_done(input string name, input logic want, input logic got);
        if (got !== want) begin
            fail_run($sformatf("ERROR %s expected %b actual %b", name, want, got));
        end
    endtask

    task automatic check_number(input string name, input int want, input int got);
        if (got != want) begin
            fail_run($sformatf("ERROR %s expected %0d actual %0d", name, want, got));
        end
    endtask

    // galois form, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic pixel_t pix_at(input int a);
        return image[`ADDR_W'(a)];
    endfunction

    // forward differences, zero on the right and bottom edges.
    function automatic grad_t expected_grad(input int a);
        grad_t g;
        g = '0;
        if (a % `IMG_W != `IMG_W - 1) begin
            g.gx = coef_t'(int'(pix_at(a + 1)) - int'(pix_at(a)));
        end
        if (a / `IMG_W != `IMG_H - 1) begin
            g.gy = coef_t'(int'(pix_at(a + `IMG_W)) - int'(pix_at(a)));
        end
        return g;
    endfunction

    task automatic fill_random();
        pixel_t p;
        for (int i = 0; i < `PIX_N; i++) begin
            for (int b = 0; b < 8; b++) begin
                p[b] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
            image[`ADDR_W'(i)] = p;
        end
    endtask

    // full-scale checkerboard, so every step is +255 or -255.
    task automatic fill_steps();
        logic [`ADDR_W-1:0] a;
        for (int i = 0; i < `PIX_N; i++) begin
            a = `ADDR_W'(i);
            image[a] = (a[0] ^ a[`ADDR_W/2]) ? 8'd255 : 8'd0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > RUN_LIMIT) begin
                fail_run($sformatf("%s: done never rose within %0d cycles", name, RUN_LIMIT));
            end
        end
    endtask

    task automatic wait_write_addr(input string name, input logic [`ADDR_W-1:0] target);
        int n;
        n = 0;
        while (!(grad_wr === 1'b1 && grad_addr === target)) begin
            @(negedge clk);
            n++;
            if (n > RUN_LIMIT) begin
                fail_run($sformatf("%s: no write to address %0d was seen", name, target));
            end
        end
    endtask

    task automatic compare_all(input string name);
        logic [`ADDR_W-1:0] a;
        for (int i = 0; i < `PIX_N; i++) begin
            a = `ADDR_W'(i);
            check_grad(name, a, expected_grad(i), grad_mem[a]);
            check_number({name, " write count"}, 1, write_count[a]);
        end
    endtask

    task automatic check_edges(input string name);
        grad_t              want;
        logic [`ADDR_W-1:0] a;
        for (int i = 0; i < `IMG_W; i++) begin
            a = {(`ADDR_W/2)'(i), (`ADDR_W/2)'(`IMG_W - 1)};
            want = expected_grad(int'(a));
            want.gx = '0;
            check_grad({name, " last column"}, a, want, grad_mem[a]);
            a = {(`ADDR_W/2)'(`IMG_H - 1), (`ADDR_W/2)'(i)};
            want = expected_grad(int'(a));
            want.gy = '0;
            check_grad({name, " last row"}, a, want, grad_mem[a]);
        end
        check_grad({name, " corner"}, `ADDR_W'(`PIX_N - 1), '0, grad_mem[`ADDR_W'(`PIX_N - 1)]);
    endtask

    task automatic check_extremes(input string name);
        grad_t      g;
        logic [3:0] seen;
        seen = '0;
        for (int i = 0; i < `PIX_N; i++) begin
            g = grad_mem[`ADDR_W'(i)];
            seen[0] = seen[0] | (g.gx == coef_t'(255));
            seen[1] = seen[1] | (g.gx == coef_t'(-255));
            seen[2] = seen[2] | (g.gy == coef_t'(255));
            seen[3] = seen[3] | (g.gy == coef_t'(-255));
        end
        check_number(name, 15, int'(seen));
    endtask

    task automatic check_idle_after_done(input string name);
        repeat (40) begin
            @(negedge clk);
            check_done({name, " done sticky"}, 1'b1, done);
            check_done({name, " img_rd idle"}, 1'b0, img_rd);
            check_done({name, " grad_wr idle"}, 1'b0, grad_wr);
        end
    endtask

    task automatic run_full(input string name);
        apply_reset();
        wait_done(name);
        compare_all(name);
        check_edges(name);
        check_idle_after_done(name);
    endtask

    // image memory, one cycle read latency.
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= image[img_addr];
        end
    end

    // gradient memory, with write order and latency checks.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            next_addr <= '0;
            for (int i = 0; i < `PIX_N; i++) begin
                write_count[i] <= 0;
            end
        end else begin
            if (img_rd) begin
                read_cycle[img_addr] <= cycle;
            end
            if (grad_wr) begin
                check_addr("write order", next_addr, grad_addr);
                check_number("write latency", LATENCY, cycle - read_cycle[grad_addr]);
                grad_mem[grad_addr]    <= grad_do;
                write_count[grad_addr] <= write_count[grad_addr] + 1;
                next_addr              <= grad_addr + `ADDR_W'(1);
            end
        end
    end

    initial begin
        reset = 1'b1;
        lfsr  = 16'd62;
        fill_random();
        run_full("random image");
        fill_steps();
        run_full("step image");
        check_extremes("step image extremes");
        fill_random();
        apply_reset();
        wait_write_addr("aborted run", `ADDR_W'(20000));
        fill_random();   // new frame, so stale words would show.
        run_full("run after reset");
        $display("sim passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/grad_pkg.sv
source/pixel_reader.sv
gradient/line_delay.sv
gradient/gradient_calc.sv
source/grad_writer.sv
source/image_gradient.sv
dv/image_gradient_properties.sv
dv/image_gradient_tb.sv

/* Makefile */
TOP := image_gradient_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
